/* src/uart_config.svh */
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Width of the clocks-per-bit divisor
`define UART_DIV_W 16

// Divisor after reset, 16 clocks per bit
// Small value keeps frames short in simulation
`define UART_DEFAULT_DIV 16

`endif

/* src/uart_pkg.sv */
`default_nettype none

`include "uart_config.svh"

package uart_pkg;

  typedef logic [7:0] byte_t;             // Serial data byte
  typedef logic [`UART_DIV_W-1:0] div_t;  // Clocks per bit
  typedef logic [3:0] count_t;            // Received characters, wraps at 16

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,       // Waiting for a start edge
    RX_START,      // Start edge seen, baud clock released
    RX_RECEIVING,  // Counting half-bit ticks
    RX_FINISH      // Byte ready, one-cycle strobe
  } rx_state_e;

  // Transmitter FSM
  typedef enum logic {
    TX_IDLE,
    TX_SHIFT
  } tx_state_e;

endpackage

`default_nettype wire

/* src/uart_rx_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Receiver results on their way to the register block
interface uart_rx_if;

  uart_pkg::byte_t data;  // Valid while strobe is high
  logic strobe;           // One-cycle pulse per received frame
  logic frame_error;      // Stop bit was 0, valid with strobe
  logic busy;             // Receiver is inside a frame

  modport source (
    output data, strobe, frame_error, busy
  );

  modport sink (
    input data, strobe, frame_error, busy
  );

endinterface

`default_nettype wire

/* src/uart_baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen #(
  parameter int HALF = 0  // Nonzero gives ticks at twice the baud rate
) (
  input  wire                 clk,
  input  wire                 rstn,
  input  wire                 restart,  // Holds the count at zero
  input  wire uart_pkg::div_t div,      // Clocks per bit
  output logic                tick      // One-cycle pulse at terminal count
);

  uart_pkg::div_t period;  // Clocks between ticks
  uart_pkg::div_t last;    // Terminal count
  uart_pkg::div_t cnt;

  assign period = (HALF != 0) ? (div >> 1) : div;
  assign last   = period - uart_pkg::div_t'(1);
  // A lowered divisor can leave cnt past last, so compare with >=
  assign tick   = !restart && (cnt >= last);

  always_ff @(posedge clk) begin
    if (!rstn || restart)
      cnt <= '0;                          // First tick one full period after release
    else if (cnt >= last)
      cnt <= '0;                          // Reload at terminal count
    else
      cnt <= cnt + uart_pkg::div_t'(1);
  end

  // Half-bit sampling needs at least two clocks per half period
  a_div_min: assert property (
    @(posedge clk) disable iff (!rstn)
    div >= uart_pkg::div_t'(4)
  );

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire        clk,
  input  wire        rstn,
  input  wire        rx,       // Serial line, already in the clk domain
  input  wire        tick,     // Half-bit tick from rx_baud
  output logic       restart,  // Keeps rx_baud cleared between frames
  uart_rx_if.source  rx_bus    // Byte, strobe and status to the register block
);

  uart_pkg::rx_state_e state;
  logic [4:0]          tick_num;  // Number of the next half-bit tick, 1 to 19
  uart_pkg::byte_t     shifter;   // LSB first, start bit falls out the bottom
  logic                stop_bit;  // Line level at the middle of the stop bit

  // Baud clock only runs inside a frame
  assign restart = (state == uart_pkg::RX_IDLE) || (state == uart_pkg::RX_FINISH);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= uart_pkg::RX_IDLE;
      tick_num <= 5'd1;
    end else begin
      case (state)
        uart_pkg::RX_IDLE: begin
          tick_num <= 5'd1;
          if (!rx)
            state <= uart_pkg::RX_START;  // Falling start edge
        end

        uart_pkg::RX_START:
          state <= uart_pkg::RX_RECEIVING;  // Generator counts from here

        uart_pkg::RX_RECEIVING: begin
          if (tick) begin
            tick_num <= tick_num + 5'd1;
            // Line back high at the middle of the start bit was a glitch
            if (tick_num == 5'd1 && rx)
              state <= uart_pkg::RX_IDLE;
            else if (tick_num == 5'd19)
              state <= uart_pkg::RX_FINISH;  // Middle of the stop bit
          end
        end

        uart_pkg::RX_FINISH:
          state <= uart_pkg::RX_IDLE;

        default:
          state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // Odd ticks land on bit middles
  // Ticks 1 to 17 cover start and data, tick 19 is the stop bit
  always_ff @(posedge clk) begin
    if (state == uart_pkg::RX_RECEIVING && tick) begin
      if (tick_num[0] && tick_num != 5'd19)
        shifter <= {rx, shifter[7:1]};  // Nine shifts leave only the data
      if (tick_num == 5'd19)
        stop_bit <= rx;
    end
  end

  assign rx_bus.data        = shifter;
  assign rx_bus.strobe      = (state == uart_pkg::RX_FINISH);
  assign rx_bus.frame_error = (state == uart_pkg::RX_FINISH) && !stop_bit;  // Stop bit low
  assign rx_bus.busy        = (state != uart_pkg::RX_IDLE);

  // Every frame gives a single strobe
  a_strobe_single: assert property (
    @(posedge clk) disable iff (!rstn)
    rx_bus.strobe |=> !rx_bus.strobe
  );

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  tx_start,  // Taken only while idle
  input  wire uart_pkg::byte_t tx_data,
  input  wire                  tick,      // Bit tick from tx_baud
  output logic                 tx,        // Serial line, idles high
  output logic                 tx_busy,
  output logic                 restart    // Keeps tx_baud cleared while idle
);

  uart_pkg::tx_state_e state;
  logic [9:0]          frame;    // Stop, data, start, sent from bit 0
  logic [3:0]          bit_cnt;  // Bit now on the line, 0 to 9

  assign tx      = frame[0];
  assign tx_busy = (state == uart_pkg::TX_SHIFT);
  assign restart = (state == uart_pkg::TX_IDLE);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= uart_pkg::TX_IDLE;
      frame   <= '1;  // Line high out of reset
      bit_cnt <= '0;
    end else begin
      case (state)
        uart_pkg::TX_IDLE: begin
          if (tx_start) begin
            frame   <= {1'b1, tx_data, 1'b0};  // Start bit goes out next cycle
            bit_cnt <= '0;
            state   <= uart_pkg::TX_SHIFT;
          end
        end

        uart_pkg::TX_SHIFT: begin
          if (tick) begin
            frame <= {1'b1, frame[9:1]};  // Ones fill in behind the frame
            if (bit_cnt == 4'd9)
              state <= uart_pkg::TX_IDLE;  // Stop bit done
            else
              bit_cnt <= bit_cnt + 4'd1;
          end
        end

        default:
          state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // After ten shifts the frame register holds only ones
  a_idle_high: assert property (
    @(posedge clk) disable iff (!rstn)
    !tx_busy |-> tx
  );

endmodule

`default_nettype wire

/* src/uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_regs (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire                   cfg_we,       // Divisor write, also clears frame_error
  input  wire uart_pkg::div_t   cfg_divisor,
  uart_rx_if.sink               rx_bus,
  output uart_pkg::div_t        div,          // Clocks per bit, to both generators
  output uart_pkg::byte_t       rx_data,      // Last received byte
  output logic                  rx_strobe,    // Aligned with rx_data
  output logic                  frame_error,  // Sticky
  output uart_pkg::count_t      rx_count      // Wraps past 15
);

  uart_pkg::div_t div_pend;  // Written value, applied once the receiver is idle

  always_ff @(posedge clk) begin
    if (!rstn) begin
      div_pend <= uart_pkg::div_t'(`UART_DEFAULT_DIV);
      div      <= uart_pkg::div_t'(`UART_DEFAULT_DIV);
    end else begin
      if (cfg_we)
        div_pend <= cfg_divisor;
      // Never change the bit period under a frame in progress
      if (!rx_bus.busy)
        div <= div_pend;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_strobe   <= 1'b0;
      rx_count    <= '0;
      frame_error <= 1'b0;
    end else begin
      rx_strobe <= rx_bus.strobe;
      if (rx_bus.strobe)
        rx_count <= rx_count + uart_pkg::count_t'(1);  // Good and bad frames alike
      // A new error wins over a clear in the same cycle
      if (rx_bus.strobe && rx_bus.frame_error)
        frame_error <= 1'b1;
      else if (cfg_we)
        frame_error <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_bus.strobe)
      rx_data <= rx_bus.data;  // Newest byte overwrites the last
  end

endmodule

`default_nettype wire

/* src/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  rx,           // Serial input
  input  wire uart_pkg::byte_t tx_data,
  input  wire                  tx_start,
  input  wire                  cfg_we,
  input  wire uart_pkg::div_t  cfg_divisor,
  output logic                 tx,           // Serial output
  output logic                 tx_busy,
  output uart_pkg::byte_t      rx_data,
  output logic                 rx_strobe,
  output logic                 frame_error,
  output uart_pkg::count_t     rx_count
);

  uart_pkg::div_t div;  // Shared clocks-per-bit setting
  logic tx_tick;
  logic tx_restart;
  logic rx_tick;       // Half-bit rate
  logic rx_restart;

  uart_rx_if rx_bus ();

  // Bit-rate ticks for the transmitter
  uart_baud_gen #(.HALF(0)) tx_baud (
    .clk     (clk),
    .rstn    (rstn),
    .restart (tx_restart),
    .div     (div),
    .tick    (tx_tick)
  );

  // Twice the bit rate for mid-bit sampling
  uart_baud_gen #(.HALF(1)) rx_baud (
    .clk     (clk),
    .rstn    (rstn),
    .restart (rx_restart),
    .div     (div),
    .tick    (rx_tick)
  );

  uart_rx u_rx (
    .clk     (clk),
    .rstn    (rstn),
    .rx      (rx),
    .tick    (rx_tick),
    .restart (rx_restart),
    .rx_bus  (rx_bus.source)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rstn     (rstn),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tick     (tx_tick),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .restart  (tx_restart)
  );

  uart_regs u_regs (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_we      (cfg_we),
    .cfg_divisor (cfg_divisor),
    .rx_bus      (rx_bus.sink),
    .div         (div),
    .rx_data     (rx_data),
    .rx_strobe   (rx_strobe),
    .frame_error (frame_error),
    .rx_count    (rx_count)
  );

endmodule

`default_nettype wire

/* verif/tb_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module tb_uart_top;

  localparam int N_FRAMES       = 18;  // 12 random, 1 busy, 3 at div 24, 2 forged
  localparam int MAX_DIV        = 24;
  localparam int TIMEOUT_CYCLES = N_FRAMES * 10 * MAX_DIV + 2000;

  logic clk;
  logic rstn;
  logic rx;
  uart_pkg::byte_t tx_data;
  logic tx_start;
  logic cfg_we;
  uart_pkg::div_t cfg_divisor;
  logic tx;
  logic tx_busy;
  uart_pkg::byte_t rx_data;
  logic rx_strobe;
  logic frame_error;
  uart_pkg::count_t rx_count;

  logic loopback;   // tx wired back into rx
  logic rx_drv;     // Forged line level
  logic [15:0] lfsr;
  logic [8:0] exp_mem [0:31];  // {bad stop, byte} per frame sent
  logic [4:0] wr_ptr;
  logic [4:0] rd_ptr;
  logic [8:0] exp_entry;
  logic ferr_model;  // Expected sticky flag
  logic we_prev;     // cfg_we seen one cycle back
  int cur_div;
  int busy_len;
  int strobes;
  int sent;
  int cycles;
  int seq_errors;
  int mon_errors;
  int prop_errors;
  uart_pkg::byte_t b;

  assign rx = loopback ? tx : rx_drv;

  uart_top uut (
    .clk(clk), .rstn(rstn), .rx(rx), .tx_data(tx_data), .tx_start(tx_start),
    .cfg_we(cfg_we), .cfg_divisor(cfg_divisor), .tx(tx), .tx_busy(tx_busy),
    .rx_data(rx_data), .rx_strobe(rx_strobe), .frame_error(frame_error),
    .rx_count(rx_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb)
      s = s ^ 16'hB400;
    return s;
  endfunction

  task automatic next_random_byte(output uart_pkg::byte_t r);
    r = '0;
    repeat (8) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      r = {r[6:0], lfsr[0]};
    end
  endtask

  task automatic expect_equal(input string name, input logic [15:0] got,
                              input logic [15:0] want);
    assert (got == want) else begin
      seq_errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  task automatic push_expected(input uart_pkg::byte_t d, input logic bad_stop);
    exp_mem[wr_ptr] = {bad_stop, d};
    wr_ptr = wr_ptr + 5'd1;
    sent++;
  endtask

  // Returns at posedge + 2 with the transmitter idle and every frame received
  task automatic wait_idle();
    do begin
      @(posedge clk);
      #2;
    end while (tx_busy || rd_ptr != wr_ptr);
  endtask

  task automatic send_byte(input uart_pkg::byte_t d);
    wait_idle();
    tx_start = 1'b1;
    tx_data  = d;
    push_expected(d, 1'b0);
    @(posedge clk);
    #2;
    tx_start = 1'b0;
  endtask

  task automatic write_divisor(input int d);
    cfg_we      = 1'b1;
    cfg_divisor = uart_pkg::div_t'(d);
    @(posedge clk);
    #2;
    cfg_we  = 1'b0;
    cur_div = d;
    repeat (2) @(posedge clk);  // Divisor reaches the generators
    #2;
  endtask

  // Drives a full frame on rx from posedge + 2 with the line idle
  task automatic forge_frame(input uart_pkg::byte_t d, input logic stop);
    logic [9:0] bits;
    bits = {stop, d, 1'b0};
    push_expected(d, ~stop);
    repeat (10) begin
      rx_drv = bits[0];
      bits   = bits >> 1;
      repeat (cur_div) @(posedge clk);
      #2;
    end
    rx_drv = 1'b1;
  endtask

  // Line stays high whenever the transmitter is idle
  a_line_idle: assert property (@(posedge clk) disable iff (!rstn) !tx_busy |-> tx)
    else begin
      prop_errors++;
      $display("Error: tx = 0x%0h while tx_busy = 0x%0h", tx, tx_busy);
    end

  always @(negedge clk) begin
    if (rstn) begin
      if (we_prev)
        ferr_model = 1'b0;  // Clear lands one edge after the write
      we_prev = cfg_we;
      if (rx_strobe) begin
        strobes++;
        if (rd_ptr == wr_ptr) begin
          mon_errors++;
          $display("Received a byte while no frame was outstanding");
        end else begin
          exp_entry = exp_mem[rd_ptr];
          rd_ptr    = rd_ptr + 5'd1;
          assert (rx_data == exp_entry[7:0]) else begin
            mon_errors++;
            $display("Error: rx_data = 0x%02h, expected 0x%02h", rx_data, exp_entry[7:0]);
          end
          if (exp_entry[8])
            ferr_model = 1'b1;  // Error wins over a clear in the same cycle
        end
      end
      assert (rx_count == strobes[3:0]) else begin
        mon_errors++;
        $display("Error: rx_count = 0x%0h, expected 0x%0h", rx_count, strobes[3:0]);
      end
      assert (frame_error == ferr_model) else begin
        mon_errors++;
        $display("Error: frame_error = 0x%0h, expected 0x%0h", frame_error, ferr_model);
      end
      if (tx_busy)
        busy_len++;
      else if (busy_len != 0) begin
        assert (busy_len >= 10 * cur_div - 1 && busy_len <= 10 * cur_div + 1) else begin
          mon_errors++;
          $display("Error: tx_busy length = 0x%0h, expected 0x%0h", busy_len, 10 * cur_div);
        end
        busy_len = 0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, frames still outstanding", cycles);
      $display("errors: seq %0d, monitor %0d, property %0d", seq_errors, mon_errors,
               prop_errors);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    rstn = 1'b0;
    tx_data = '0;
    tx_start = 1'b0;
    cfg_we = 1'b0;
    cfg_divisor = uart_pkg::div_t'(`UART_DEFAULT_DIV);
    loopback = 1'b1;
    rx_drv = 1'b1;
    lfsr = 16'd32598;
    wr_ptr = '0;
    rd_ptr = '0;
    ferr_model = 1'b0;
    we_prev = 1'b0;
    cur_div = `UART_DEFAULT_DIV;
    busy_len = 0;
    strobes = 0;
    sent = 0;
    cycles = 0;
    seq_errors = 0;
    mon_errors = 0;
    prop_errors = 0;
    repeat (8) @(posedge clk);
    #2;
    rstn = 1'b1;
    @(posedge clk);
    #2;
    expect_equal("tx", 16'(tx), 16'h1);
    expect_equal("tx_busy", 16'(tx_busy), 16'h0);
    expect_equal("rx_strobe", 16'(rx_strobe), 16'h0);
    expect_equal("frame_error", 16'(frame_error), 16'h0);
    expect_equal("rx_count", 16'(rx_count), 16'h0);
    repeat (12) begin
      next_random_byte(b);
      send_byte(b);
    end
    // Start pulse in the middle of a frame must be dropped
    next_random_byte(b);
    send_byte(b);
    repeat (3) @(posedge clk);
    #2;
    expect_equal("tx_busy", 16'(tx_busy), 16'h1);
    tx_start = 1'b1;
    tx_data  = ~b;
    @(posedge clk);
    #2;
    tx_start = 1'b0;
    wait_idle();
    write_divisor(24);
    repeat (3) begin
      next_random_byte(b);
      send_byte(b);
    end
    wait_idle();
    loopback = 1'b0;  // rx now from rx_drv
    next_random_byte(b);
    forge_frame(b, 1'b0);  // Stop bit low
    wait_idle();
    expect_equal("frame_error", 16'(frame_error), 16'h1);
    write_divisor(24);     // Any write clears the flag
    next_random_byte(b);
    forge_frame(b, 1'b1);
    wait_idle();
    expect_equal("frame_error", 16'(frame_error), 16'h0);
    expect_equal("strobes", 16'(strobes), 16'(sent));
    $display("errors: seq %0d, monitor %0d, property %0d", seq_errors, mon_errors,
             prop_errors);
    if (seq_errors + mon_errors + prop_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/uart_pkg.sv
src/uart_rx_if.sv
src/uart_baud_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_regs.sv
src/uart_top.sv
verif/tb_uart_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_uart_top

out=$(./obj_dir/Vtb_uart_top)
echo "$out"

if echo "$out" | grep -q "^TB PASSED$"; then
  exit 0
fi
exit 1
